//--- design/rv_pkg.sv
package rv_pkg;

    localparam int XLEN = 32;

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    // alu funct3 codes
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // load/store width codes
    localparam logic [2:0] F3_BYTE   = 3'b000;
    localparam logic [2:0] F3_WORD   = 3'b010;
    localparam logic [2:0] F3_BYTE_U = 3'b100;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_MEMORY,
        ST_WRITE
    } stage_t;

    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_PC_P4
    } res_src_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] pc_p4;
        logic [4:0]      rd;
        logic [XLEN-1:0] imm;
        alu_op_t         alu_op;
        logic            op2_imm;
        logic            reg_write;
        logic            mem_read;
        logic            mem_write;
        res_src_t        res_src;
        logic            branch;
        logic            branch_ne;
        logic            jump;
        logic [2:0]      funct3;
    } dec_ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] alu_result;
        logic [XLEN-1:0] rs2_val;
        logic [4:0]      rd;
        logic [XLEN-1:0] pc_p4;
        logic            reg_write;
        logic            mem_read;
        logic            mem_write;
        res_src_t        res_src;
        logic [2:0]      funct3;
    } exec_res_t;

    typedef struct packed {
        logic [4:0]      rd;
        logic            reg_write;
        logic [XLEN-1:0] data;
    } wb_res_t;

endpackage

//--- design/rv_fetch.sv
`timescale 1ns/10ps

module rv_fetch
    import rv_pkg::*;
#(
    parameter logic [31:0] RESET_ADDR = 32'h0000_0000
)
(
    input  logic            i_clk,
    input  logic            i_reset_n,
    input  logic            i_update,
    input  logic            i_pc_sel,
    input  logic [XLEN-1:0] i_pc_target,
    output logic [XLEN-1:0] o_pc,
    output logic [XLEN-1:0] o_pc_p4
);

    logic [XLEN-1:0] pc;

    assign o_pc    = pc;
    assign o_pc_p4 = pc + 32'd4;

    // pc moves once per instruction, in the write stage
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            pc <= RESET_ADDR;
        end
        else if (i_update)
        begin
            if (i_pc_sel)
            begin
                pc <= i_pc_target;
            end
            else
            begin
                pc <= o_pc_p4;
            end
        end
    end

endmodule

//--- design/rv_decode.sv
`timescale 1ns/10ps

module rv_decode
    import rv_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_reset_n,
    input  logic            i_fetch_en,
    input  logic            i_decode_en,
    input  logic [XLEN-1:0] i_inst,
    input  logic [XLEN-1:0] i_pc,
    input  logic [XLEN-1:0] i_pc_p4,
    output logic [4:0]      o_rs1,
    output logic [4:0]      o_rs2,
    output dec_ctrl_t       o_ctrl
);

    logic [XLEN-1:0] inst;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_p4;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    dec_ctrl_t       ctrl_next;

    function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic sub);
        case (f3)
            F3_ADD:  return sub ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_XOR:  return ALU_XOR;
            F3_SRL:  return ALU_SRL;
            F3_OR:   return ALU_OR;
            F3_AND:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    always_ff @(posedge i_clk)
    begin
        if (i_fetch_en)
        begin
            inst  <= i_inst;
            pc    <= i_pc;
            pc_p4 <= i_pc_p4;
        end
    end

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign o_rs1  = inst[19:15];
    assign o_rs2  = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb
    begin
        ctrl_next         = '0;
        ctrl_next.pc      = pc;
        ctrl_next.pc_p4   = pc_p4;
        ctrl_next.rd      = inst[11:7];
        ctrl_next.funct3  = funct3;
        ctrl_next.alu_op  = ALU_ADD;
        ctrl_next.res_src = RES_ALU;
        case (opcode)
            OP_LUI:
            begin
                ctrl_next.imm       = imm_u;
                ctrl_next.alu_op    = ALU_PASS_B;
                ctrl_next.op2_imm   = 1'b1;
                ctrl_next.reg_write = 1'b1;
            end
            OP_JAL:
            begin
                ctrl_next.imm       = imm_j;
                ctrl_next.jump      = 1'b1;
                ctrl_next.reg_write = 1'b1;
                ctrl_next.res_src   = RES_PC_P4;
            end
            OP_BRANCH:
            begin
                ctrl_next.imm       = imm_b;
                ctrl_next.branch    = 1'b1;
                ctrl_next.branch_ne = funct3[0];
            end
            OP_LOAD:
            begin
                ctrl_next.imm       = imm_i;
                ctrl_next.op2_imm   = 1'b1;
                ctrl_next.mem_read  = 1'b1;
                ctrl_next.reg_write = 1'b1;
                ctrl_next.res_src   = RES_MEM;
            end
            OP_STORE:
            begin
                ctrl_next.imm       = imm_s;
                ctrl_next.op2_imm   = 1'b1;
                ctrl_next.mem_write = 1'b1;
            end
            OP_IMM:
            begin
                ctrl_next.imm       = imm_i;
                ctrl_next.op2_imm   = 1'b1;
                ctrl_next.reg_write = 1'b1;
                ctrl_next.alu_op    = alu_sel(funct3, 1'b0);
            end
            OP_REG:
            begin
                ctrl_next.reg_write = 1'b1;
                ctrl_next.alu_op    = alu_sel(funct3, funct7[5]);
            end
            // anything else passes through as a nop
            default:
            begin
                ctrl_next.reg_write = 1'b0;
            end
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_ctrl <= '0;
        end
        else if (i_decode_en)
        begin
            o_ctrl <= ctrl_next;
        end
    end

endmodule

//--- design/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile
    import rv_pkg::*;
(
    input  logic            i_clk,
    input  logic [4:0]      i_rs1,
    input  logic [4:0]      i_rs2,
    output logic [XLEN-1:0] o_rs1_val,
    output logic [XLEN-1:0] o_rs2_val,
    input  wb_res_t         i_wb,
    input  logic            i_write_en
);

    // x0 has no storage
    logic [XLEN-1:0] regs [31:1];

    assign o_rs1_val = (i_rs1 != 5'd0) ? regs[i_rs1] : '0;
    assign o_rs2_val = (i_rs2 != 5'd0) ? regs[i_rs2] : '0;

    always_ff @(posedge i_clk)
    begin
        if (i_write_en && i_wb.reg_write && (i_wb.rd != 5'd0))
        begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

endmodule

//--- design/rv_exec.sv
`timescale 1ns/10ps

module rv_exec
    import rv_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_exec_en,
    input  dec_ctrl_t       i_ctrl,
    input  logic [XLEN-1:0] i_rs1_val,
    input  logic [XLEN-1:0] i_rs2_val,
    output exec_res_t       o_res,
    output logic            o_pc_sel,
    output logic [XLEN-1:0] o_pc_target
);

    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_out;
    logic            equal;
    logic            take;

    assign op_b = i_ctrl.op2_imm ? i_ctrl.imm : i_rs2_val;

    always_comb
    begin
        case (i_ctrl.alu_op)
            ALU_ADD:    alu_out = i_rs1_val + op_b;
            ALU_SUB:    alu_out = i_rs1_val - op_b;
            ALU_AND:    alu_out = i_rs1_val & op_b;
            ALU_OR:     alu_out = i_rs1_val | op_b;
            ALU_XOR:    alu_out = i_rs1_val ^ op_b;
            ALU_SLT:    alu_out = {31'b0, $signed(i_rs1_val) < $signed(op_b)};
            ALU_SLL:    alu_out = i_rs1_val << op_b[4:0];
            ALU_SRL:    alu_out = i_rs1_val >> op_b[4:0];
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    // beq and bne only differ in the sense of the compare
    assign equal = (i_rs1_val == i_rs2_val);
    assign take  = i_ctrl.jump | (i_ctrl.branch & (equal ^ i_ctrl.branch_ne));

    always_ff @(posedge i_clk)
    begin
        if (i_exec_en)
        begin
            o_res.alu_result <= alu_out;
            o_res.rs2_val    <= i_rs2_val;
            o_res.rd         <= i_ctrl.rd;
            o_res.pc_p4      <= i_ctrl.pc_p4;
            o_res.reg_write  <= i_ctrl.reg_write;
            o_res.mem_read   <= i_ctrl.mem_read;
            o_res.mem_write  <= i_ctrl.mem_write;
            o_res.res_src    <= i_ctrl.res_src;
            o_res.funct3     <= i_ctrl.funct3;
            o_pc_sel         <= take;
            o_pc_target      <= i_ctrl.pc + i_ctrl.imm;
        end
    end

endmodule

//--- design/rv_lsu.sv
`timescale 1ns/10ps

module rv_lsu
    import rv_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_reset_n,
    input  logic            i_mem_en,
    input  exec_res_t       i_res,
    output logic            o_mem_done,
    output wb_res_t         o_wb,
    output logic [XLEN-1:0] o_wb_adr,
    output logic [XLEN-1:0] o_wb_dat,
    input  logic [XLEN-1:0] i_wb_dat,
    output logic            o_wb_we,
    output logic [3:0]      o_wb_sel,
    output logic            o_wb_stb,
    input  logic            i_wb_ack,
    output logic            o_wb_cyc
);

    logic            access;
    logic [7:0]      load_byte;
    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] result;
    wb_res_t         wb_reg;

    assign access = i_res.mem_read | i_res.mem_write;

    // held by the sequencer in the memory stage until ack
    assign o_wb_stb   = i_mem_en & access;
    assign o_wb_cyc   = i_mem_en & access;
    assign o_wb_we    = i_mem_en & i_res.mem_write;
    assign o_wb_adr   = i_res.alu_result;
    assign o_mem_done = i_mem_en & (access ? i_wb_ack : 1'b1);

    always_comb
    begin
        if (i_res.funct3 == F3_BYTE)
        begin
            o_wb_dat = {4{i_res.rs2_val[7:0]}};
            o_wb_sel = 4'b0001 << i_res.alu_result[1:0];
        end
        else
        begin
            o_wb_dat = i_res.rs2_val;
            o_wb_sel = 4'b1111;
        end
    end

    // lbu picks its lane, anything else is a full word
    assign load_byte = i_wb_dat[8*i_res.alu_result[1:0] +: 8];
    assign load_data = (i_res.funct3 == F3_BYTE_U) ? {24'b0, load_byte} : i_wb_dat;

    always_comb
    begin
        case (i_res.res_src)
            RES_MEM:   result = load_data;
            RES_PC_P4: result = i_res.pc_p4;
            default:   result = i_res.alu_result;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            wb_reg.rd        <= 5'd0;
            wb_reg.reg_write <= 1'b0;
        end
        else if (o_mem_done)
        begin
            wb_reg.rd        <= i_res.rd;
            wb_reg.reg_write <= i_res.reg_write;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (o_mem_done)
        begin
            wb_reg.data <= result;
        end
    end

    assign o_wb = wb_reg;

endmodule

//--- design/rv_stage_ctrl.sv
`timescale 1ns/10ps

module rv_stage_ctrl
    import rv_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_reset_n,
    input  logic   i_mem_done,
    output stage_t o_stage,
    output logic   o_fetch_en,
    output logic   o_decode_en,
    output logic   o_exec_en,
    output logic   o_mem_en,
    output logic   o_write_en
);

    stage_t stage;
    stage_t stage_next;

    always_comb
    begin
        case (stage)
            ST_FETCH:   stage_next = ST_DECODE;
            ST_DECODE:  stage_next = ST_EXECUTE;
            ST_EXECUTE: stage_next = ST_MEMORY;
            // stay here while the bus withholds ack
            ST_MEMORY:  stage_next = i_mem_done ? ST_WRITE : ST_MEMORY;
            ST_WRITE:   stage_next = ST_FETCH;
            default:    stage_next = ST_FETCH;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            stage <= ST_FETCH;
        end
        else
        begin
            stage <= stage_next;
        end
    end

    assign o_stage     = stage;
    assign o_fetch_en  = (stage == ST_FETCH);
    assign o_decode_en = (stage == ST_DECODE);
    assign o_exec_en   = (stage == ST_EXECUTE);
    assign o_mem_en    = (stage == ST_MEMORY);
    assign o_write_en  = (stage == ST_WRITE);

endmodule

//--- design/rv_core.sv
`timescale 1ns/10ps

module rv_core
    import rv_pkg::*;
#(
    parameter logic [31:0] RESET_ADDR = 32'h0000_0000
)
(
    input  logic            i_clk,
    input  logic            i_reset_n,
    output logic [XLEN-1:0] o_inst_addr,
    input  logic [XLEN-1:0] i_inst,
    output logic [XLEN-1:0] o_wb_adr,
    output logic [XLEN-1:0] o_wb_dat,
    input  logic [XLEN-1:0] i_wb_dat,
    output logic            o_wb_we,
    output logic [3:0]      o_wb_sel,
    output logic            o_wb_stb,
    input  logic            i_wb_ack,
    output logic            o_wb_cyc
);

    stage_t          stage;
    logic            fetch_en;
    logic            decode_en;
    logic            exec_en;
    logic            mem_en;
    logic            write_en;
    logic            mem_done;
    logic [XLEN-1:0] pc_p4;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    dec_ctrl_t       dec_ctrl;
    exec_res_t       exec_res;
    wb_res_t         wb_res;
    logic            pc_sel;
    logic [XLEN-1:0] pc_target;

    rv_stage_ctrl u_stage_ctrl (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_mem_done  (mem_done),
        .o_stage     (stage),
        .o_fetch_en  (fetch_en),
        .o_decode_en (decode_en),
        .o_exec_en   (exec_en),
        .o_mem_en    (mem_en),
        .o_write_en  (write_en)
    );

    rv_fetch #(
        .RESET_ADDR (RESET_ADDR)
    ) u_fetch (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_update    (write_en),
        .i_pc_sel    (pc_sel),
        .i_pc_target (pc_target),
        .o_pc        (o_inst_addr),
        .o_pc_p4     (pc_p4)
    );

    rv_decode u_decode (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_fetch_en  (fetch_en),
        .i_decode_en (decode_en),
        .i_inst      (i_inst),
        .i_pc        (o_inst_addr),
        .i_pc_p4     (pc_p4),
        .o_rs1       (rs1),
        .o_rs2       (rs2),
        .o_ctrl      (dec_ctrl)
    );

    rv_regfile u_regfile (
        .i_clk      (i_clk),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .o_rs1_val  (rs1_val),
        .o_rs2_val  (rs2_val),
        .i_wb       (wb_res),
        .i_write_en (write_en)
    );

    rv_exec u_exec (
        .i_clk       (i_clk),
        .i_exec_en   (exec_en),
        .i_ctrl      (dec_ctrl),
        .i_rs1_val   (rs1_val),
        .i_rs2_val   (rs2_val),
        .o_res       (exec_res),
        .o_pc_sel    (pc_sel),
        .o_pc_target (pc_target)
    );

    rv_lsu u_lsu (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_mem_en   (mem_en),
        .i_res      (exec_res),
        .o_mem_done (mem_done),
        .o_wb       (wb_res),
        .o_wb_adr   (o_wb_adr),
        .o_wb_dat   (o_wb_dat),
        .i_wb_dat   (i_wb_dat),
        .o_wb_we    (o_wb_we),
        .o_wb_sel   (o_wb_sel),
        .o_wb_stb   (o_wb_stb),
        .i_wb_ack   (i_wb_ack),
        .o_wb_cyc   (o_wb_cyc)
    );

endmodule

//--- verification/rv_tb_program.svh
// program image, one word per instruction, starting at the reset address
task automatic load_program();
    place_inst(32'h06400093);  // 00 addi x1, x0, 100
    place_inst(32'hff900113);  // 04 addi x2, x0, -7
    place_inst(32'h123451b7);  // 08 lui  x3, 0x12345
    place_inst(32'h00400713);  // 0c addi x14, x0, 4
    place_inst(32'h00102023);  // 10 sw   x1, 0x00(x0)
    place_inst(32'h00202223);  // 14 sw   x2, 0x04(x0)
    place_inst(32'h00302423);  // 18 sw   x3, 0x08(x0)
    place_inst(32'h00208233);  // 1c add  x4, x1, x2
    place_inst(32'h00402623);  // 20 sw   x4, 0x0c(x0)
    place_inst(32'h401102b3);  // 24 sub  x5, x2, x1
    place_inst(32'h00502823);  // 28 sw   x5, 0x10(x0)
    place_inst(32'h0020f333);  // 2c and  x6, x1, x2
    place_inst(32'h00602a23);  // 30 sw   x6, 0x14(x0)
    place_inst(32'h0020e3b3);  // 34 or   x7, x1, x2
    place_inst(32'h00702c23);  // 38 sw   x7, 0x18(x0)
    place_inst(32'h0020c433);  // 3c xor  x8, x1, x2
    place_inst(32'h00802e23);  // 40 sw   x8, 0x1c(x0)
    place_inst(32'h001124b3);  // 44 slt  x9, x2, x1
    place_inst(32'h02902023);  // 48 sw   x9, 0x20(x0)
    place_inst(32'h0020a533);  // 4c slt  x10, x1, x2
    place_inst(32'h02a02223);  // 50 sw   x10, 0x24(x0)
    place_inst(32'hffa12593);  // 54 slti x11, x2, -6
    place_inst(32'h02b02423);  // 58 sw   x11, 0x28(x0)
    place_inst(32'hfff0a613);  // 5c slti x12, x1, -1
    place_inst(32'h02c02623);  // 60 sw   x12, 0x2c(x0)
    place_inst(32'h00e196b3);  // 64 sll  x13, x3, x14
    place_inst(32'h02d02823);  // 68 sw   x13, 0x30(x0)
    place_inst(32'h00e157b3);  // 6c srl  x15, x2, x14
    place_inst(32'h02f02a23);  // 70 sw   x15, 0x34(x0)
    place_inst(32'h03700013);  // 74 addi x0, x0, 55
    place_inst(32'h02002c23);  // 78 sw   x0, 0x38(x0)
    place_inst(32'h08002803);  // 7c lw   x16, 0x80(x0)
    place_inst(32'h03002e23);  // 80 sw   x16, 0x3c(x0)
    place_inst(32'h08204883);  // 84 lbu  x17, 0x82(x0)
    place_inst(32'h05102023);  // 88 sw   x17, 0x40(x0)
    place_inst(32'h04200223);  // 8c sb   x2, 0x44(x0)
    place_inst(32'h042002a3);  // 90 sb   x2, 0x45(x0)
    place_inst(32'h04200323);  // 94 sb   x2, 0x46(x0)
    place_inst(32'h042003a3);  // 98 sb   x2, 0x47(x0)
    place_inst(32'h00108463);  // 9c beq  x1, x1, +8
    place_inst(32'h04202423);  // a0 sw   x2, 0x48(x0)   skipped
    place_inst(32'h04102423);  // a4 sw   x1, 0x48(x0)
    place_inst(32'h00109463);  // a8 bne  x1, x1, +8
    place_inst(32'h04402623);  // ac sw   x4, 0x4c(x0)
    place_inst(32'h0080096f);  // b0 jal  x18, +8
    place_inst(32'h04202823);  // b4 sw   x2, 0x50(x0)   skipped
    place_inst(32'h05202823);  // b8 sw   x18, 0x50(x0)
    place_inst(32'h0000006f);  // bc jal  x0, 0
endtask

// bus writes in program order: name, address, data, byte select
task automatic build_store_table();
    expect_store("addi pos", 32'h0000_0000, 32'h0000_0064, 4'hf);
    expect_store("addi neg", 32'h0000_0004, 32'hffff_fff9, 4'hf);
    expect_store("lui",      32'h0000_0008, 32'h1234_5000, 4'hf);
    expect_store("add",      32'h0000_000c, 32'h0000_005d, 4'hf);
    expect_store("sub",      32'h0000_0010, 32'hffff_ff95, 4'hf);
    expect_store("and",      32'h0000_0014, 32'h0000_0060, 4'hf);
    expect_store("or",       32'h0000_0018, 32'hffff_fffd, 4'hf);
    expect_store("xor",      32'h0000_001c, 32'hffff_ff9d, 4'hf);
    expect_store("slt neg",  32'h0000_0020, 32'h0000_0001, 4'hf);
    expect_store("slt pos",  32'h0000_0024, 32'h0000_0000, 4'hf);
    expect_store("slti neg", 32'h0000_0028, 32'h0000_0001, 4'hf);
    expect_store("slti pos", 32'h0000_002c, 32'h0000_0000, 4'hf);
    expect_store("sll",      32'h0000_0030, 32'h2345_0000, 4'hf);
    expect_store("srl",      32'h0000_0034, 32'h0fff_ffff, 4'hf);
    expect_store("x0 zero",  32'h0000_0038, 32'h0000_0000, 4'hf);
    expect_store("lw",       32'h0000_003c, 32'ha5c3_9e17, 4'hf);
    expect_store("lbu",      32'h0000_0040, 32'h0000_00c3, 4'hf);
    expect_store("sb off 0", 32'h0000_0044, 32'hf9f9_f9f9, 4'h1);
    expect_store("sb off 1", 32'h0000_0045, 32'hf9f9_f9f9, 4'h2);
    expect_store("sb off 2", 32'h0000_0046, 32'hf9f9_f9f9, 4'h4);
    expect_store("sb off 3", 32'h0000_0047, 32'hf9f9_f9f9, 4'h8);
    expect_store("beq take", 32'h0000_0048, 32'h0000_0064, 4'hf);
    expect_store("bne fall", 32'h0000_004c, 32'h0000_005d, 4'hf);
    expect_store("jal link", 32'h0000_0050, 32'h0000_00b4, 4'hf);
endtask

//--- verification/rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb;

    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } bus_write_t;

    typedef struct packed {
        logic [63:0] name;
        bus_write_t  wr;
    } store_entry_t;

    localparam int          IMEM_WORDS = 64;
    localparam int          DMEM_WORDS = 64;
    localparam logic [31:0] NOP        = 32'h0000_0013;

    logic         clk;
    logic         reset_n;
    logic [31:0]  inst_addr;
    logic [31:0]  inst;
    logic [31:0]  wb_adr;
    logic [31:0]  wb_wdata;
    logic [31:0]  wb_rdata;
    logic         wb_we;
    logic [3:0]   wb_sel;
    logic         wb_stb;
    logic         wb_ack;
    logic         wb_cyc;

    logic [31:0]  imem [0:IMEM_WORDS-1];
    logic [31:0]  dmem [0:DMEM_WORDS-1];
    int           inst_count;
    logic [31:0]  inst_word;
    store_entry_t expected_q [$];
    bus_write_t   observed_q [$];
    int           cycle_count;
    int           cycle_limit;
    logic         pending;
    int unsigned  waits;
    bus_write_t   held_req;
    logic         held_we;
    logic [5:0]   dmem_idx;
    int           lane;
    int           idx;
    int unsigned  seed;
    int unsigned  seed_draw;
    bus_write_t   got;
    store_entry_t want;

    rv_core #(
        .RESET_ADDR (32'h0000_0000)
    ) u_dut (
        .i_clk       (clk),
        .i_reset_n   (reset_n),
        .o_inst_addr (inst_addr),
        .i_inst      (inst),
        .o_wb_adr    (wb_adr),
        .o_wb_dat    (wb_wdata),
        .i_wb_dat    (wb_rdata),
        .o_wb_we     (wb_we),
        .o_wb_sel    (wb_sel),
        .o_wb_stb    (wb_stb),
        .i_wb_ack    (wb_ack),
        .o_wb_cyc    (wb_cyc)
    );

    always #10 clk = ~clk;

    // instruction memory answers in the same cycle
    assign inst_word = inst_addr >> 2;
    assign inst      = (inst_word < inst_count) ? imem[inst_word] : NOP;

    task automatic place_inst(input logic [31:0] word);
        imem[inst_count] = word;
        inst_count = inst_count + 1;
    endtask

    task automatic expect_store(input logic [63:0] name, input logic [31:0] adr,
                                input logic [31:0] dat, input logic [3:0] sel);
        store_entry_t entry;
        entry.name   = name;
        entry.wr.adr = adr;
        entry.wr.dat = dat;
        entry.wr.sel = sel;
        expected_q.push_back(entry);
    endtask

    task automatic check_value(input logic [63:0] test_name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("ERROR %0s %0s: expected %h, actual %h",
                     test_name, field, expected, actual);
            $display("** FAIL **");
            $fatal(1, "store check mismatch");
        end
    endtask

    `include "rv_tb_program.svh"

    // data slave with random waits
    always @(posedge clk)
    begin
        #1;
        check_value("bus cyc", "cyc", {31'b0, wb_stb}, {31'b0, wb_cyc});
        if (!wb_stb)
        begin
            check_value("bus idle", "we", 32'd0, {31'b0, wb_we});
        end
        if (wb_ack)
        begin
            wb_ack   = 1'b0;
            wb_rdata = '0;
        end
        else if (wb_stb && wb_cyc)
        begin
            if (!pending)
            begin
                pending  = 1'b1;
                // reads always wait at least one cycle
                waits    = wb_we ? $urandom_range(3, 0) : $urandom_range(3, 1);
                held_req = {wb_adr, wb_wdata, wb_sel};
                held_we  = wb_we;
            end
            else
            begin
                check_value("bus hold", "adr", held_req.adr, wb_adr);
                check_value("bus hold", "dat", held_req.dat, wb_wdata);
                check_value("bus hold", "sel", {28'b0, held_req.sel}, {28'b0, wb_sel});
                check_value("bus hold", "we", {31'b0, held_we}, {31'b0, wb_we});
            end
            if (waits == 0)
            begin
                dmem_idx = wb_adr[7:2];
                if (wb_we)
                begin
                    for (lane = 0; lane < 4; lane++)
                    begin
                        if (wb_sel[lane])
                        begin
                            dmem[dmem_idx][8*lane +: 8] = wb_wdata[8*lane +: 8];
                        end
                    end
                    observed_q.push_back({wb_adr, wb_wdata, wb_sel});
                end
                else
                begin
                    wb_rdata = dmem[dmem_idx];
                end
                wb_ack  = 1'b1;
                pending = 1'b0;
            end
            else
            begin
                waits = waits - 1;
            end
        end
    end

    always @(posedge clk)
    begin
        if (reset_n)
        begin
            cycle_count = cycle_count + 1;
            if (cycle_count > cycle_limit)
            begin
                $display("TIMEOUT: the store sequence did not complete within %0d cycles",
                         cycle_limit);
                $display("** FAIL **");
                $fatal(1, "simulation stopped by the cycle limit");
            end
        end
    end

    initial
    begin
        clk         = 1'b0;
        reset_n     = 1'b0;
        wb_rdata    = '0;
        wb_ack      = 1'b0;
        pending     = 1'b0;
        waits       = 0;
        held_req    = '0;
        held_we     = 1'b0;
        cycle_count = 0;
        inst_count  = 0;
        seed        = 32'h51a1d975;
        seed_draw   = $urandom(seed);

        for (idx = 0; idx < DMEM_WORDS; idx++)
        begin
            dmem[idx] = 32'hd0d0_0000 | (idx << 2);
        end
        // load source word and its neighbour
        dmem[32] = 32'ha5c3_9e17;
        dmem[33] = 32'h5a3c_61e8;

        load_program();
        build_store_table();
        // twice the worst case of 8 cycles per instruction
        cycle_limit = inst_count * 8 * 2;

        repeat (8) @(posedge clk);
        #1;
        reset_n = 1'b1;

        for (idx = 0; idx < expected_q.size(); idx++)
        begin
            while (observed_q.size() == 0)
            begin
                @(posedge clk);
            end
            got  = observed_q.pop_front();
            want = expected_q[idx];
            check_value(want.name, "adr", want.wr.adr, got.adr);
            check_value(want.name, "dat", want.wr.dat, got.dat);
            check_value(want.name, "sel", {28'b0, want.wr.sel}, {28'b0, got.sel});
        end

        // program now spins on its last jal and the bus stays quiet
        repeat (32) @(posedge clk);
        check_value("no extra", "stores", 32'd0, observed_q.size());

        $display("** PASS **");
        $finish;
    end

endmodule

//--- all.f
+incdir+verification
design/rv_pkg.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_exec.sv
design/rv_lsu.sv
design/rv_stage_ctrl.sv
design/rv_core.sv
verification/rv_core_tb.sv
